/* hdl/io_buffer_consts.svh */
`ifndef IO_BUFFER_CONSTS_SVH
`define IO_BUFFER_CONSTS_SVH

// word address and bank split
`define IOB_ADDR_W     12
`define IOB_BANK_AW    10
`define IOB_BANK_SEL_W 2
`define IOB_BANKS      4

// data word and byte lanes
`define IOB_DATA_W     256
`define IOB_BE_W       32

`endif

/* hdl/iob_pkg.sv */
`include "io_buffer_consts.svh"

package iob_pkg;

  typedef logic [`IOB_ADDR_W-1:0] addr_t;
  typedef logic [`IOB_DATA_W-1:0] data_t;
  typedef logic [`IOB_BE_W-1:0]   be_t;

  // ----------------------------------------
  // requests from outside
  // ----------------------------------------

  // bus controller side, read when we is low
  typedef struct packed {
    logic  en;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } ext_req_t;

  // pad wins over a read
  typedef struct packed {
    logic  en;
    logic  pad;
    addr_t addr;
  } int_rd_req_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t wdata;
  } int_wr_req_t;

  // ----------------------------------------
  // internal traffic
  // ----------------------------------------

  // one port of one bank
  typedef struct packed {
    logic                    en;
    logic                    we;
    be_t                     be;
    logic [`IOB_BANK_AW-1:0] addr;
    data_t                   wdata;
  } bank_cmd_t;

  // follows the bank read data by one cycle
  typedef struct packed {
    logic                       int_vld;
    logic                       pad;
    logic                       blocked;
    logic [`IOB_BANK_SEL_W-1:0] int_bank;
    logic                       ext_vld;
    logic [`IOB_BANK_SEL_W-1:0] ext_bank;
  } rd_tag_t;

endpackage

/* hdl/iob_decode.sv */
`timescale 1ns/1ps
`include "io_buffer_consts.svh"

module iob_decode (
  input  iob_pkg::ext_req_t    i_ext_req,
  input  iob_pkg::int_rd_req_t i_int_rd,
  input  iob_pkg::int_wr_req_t i_int_wr,
  output iob_pkg::bank_cmd_t   o_port0_cmd [`IOB_BANKS],
  output iob_pkg::bank_cmd_t   o_port1_cmd [`IOB_BANKS],
  output iob_pkg::rd_tag_t     o_tag
);

  localparam int SEL_W = `IOB_BANK_SEL_W;

  logic [SEL_W-1:0] ext_bank;
  logic [SEL_W-1:0] rd_bank;
  logic [SEL_W-1:0] wr_bank;
  logic             ext_wr;
  logic             ext_rd;
  logic             int_rd;

  // top address bits pick the bank
  assign ext_bank = i_ext_req.addr[`IOB_ADDR_W-1 -: SEL_W];
  assign rd_bank  = i_int_rd.addr[`IOB_ADDR_W-1 -: SEL_W];
  assign wr_bank  = i_int_wr.addr[`IOB_ADDR_W-1 -: SEL_W];

  assign ext_wr = i_ext_req.en & i_ext_req.we;
  assign ext_rd = i_ext_req.en & ~i_ext_req.we;
  // no bank access for a pad
  assign int_rd = i_int_rd.en & ~i_int_rd.pad;

  // ----------------------------------------
  // port steering, external side first
  // ----------------------------------------
  always_comb begin
    for (int b = 0; b < `IOB_BANKS; b++) begin
      o_port0_cmd[b] = '0;
      o_port1_cmd[b] = '0;

      // port 0: external write, else internal read
      if (ext_wr && ext_bank == SEL_W'(b)) begin
        o_port0_cmd[b].en    = 1'b1;
        o_port0_cmd[b].we    = 1'b1;
        o_port0_cmd[b].be    = i_ext_req.be;
        o_port0_cmd[b].addr  = i_ext_req.addr[`IOB_BANK_AW-1:0];
        o_port0_cmd[b].wdata = i_ext_req.wdata;
      end else if (int_rd && rd_bank == SEL_W'(b)) begin
        o_port0_cmd[b].en   = 1'b1;
        o_port0_cmd[b].addr = i_int_rd.addr[`IOB_BANK_AW-1:0];
      end

      // port 1: external read, else internal write
      if (ext_rd && ext_bank == SEL_W'(b)) begin
        o_port1_cmd[b].en   = 1'b1;
        o_port1_cmd[b].addr = i_ext_req.addr[`IOB_BANK_AW-1:0];
      end else if (i_int_wr.en && wr_bank == SEL_W'(b)) begin
        o_port1_cmd[b].en    = 1'b1;
        o_port1_cmd[b].we    = 1'b1;
        o_port1_cmd[b].be    = '1;
        o_port1_cmd[b].addr  = i_int_wr.addr[`IOB_BANK_AW-1:0];
        o_port1_cmd[b].wdata = i_int_wr.wdata;
      end
    end
  end

  // read tag, blocked means port 0 went to the bus write
  assign o_tag = '{
    int_vld:  i_int_rd.en | i_int_rd.pad,
    pad:      i_int_rd.pad,
    blocked:  int_rd & ext_wr & (ext_bank == rd_bank),
    int_bank: rd_bank,
    ext_vld:  ext_rd,
    ext_bank: ext_bank
  };

endmodule

/* hdl/iob_bank.sv */
`timescale 1ns/1ps
`include "io_buffer_consts.svh"

module iob_bank (
  input  logic               i_clk,
  input  iob_pkg::bank_cmd_t i_port0_cmd,
  input  iob_pkg::bank_cmd_t i_port1_cmd,
  output iob_pkg::data_t     o_port0_rdata,
  output iob_pkg::data_t     o_port1_rdata
);

  iob_pkg::data_t mem [2**`IOB_BANK_AW];

  // sram-like, read data holds while the port is idle
  always_ff @(posedge i_clk) begin
    // port 0 writes per byte lane
    if (i_port0_cmd.en) begin
      if (i_port0_cmd.we) begin
        for (int i = 0; i < `IOB_BE_W; i++) begin
          if (i_port0_cmd.be[i]) begin
            mem[i_port0_cmd.addr][8*i +: 8] <= i_port0_cmd.wdata[8*i +: 8];
          end
        end
      end else begin
        o_port0_rdata <= mem[i_port0_cmd.addr];
      end
    end

    // port 1 writes the whole word
    if (i_port1_cmd.en) begin
      if (i_port1_cmd.we) begin
        mem[i_port1_cmd.addr] <= i_port1_cmd.wdata;
      end else begin
        o_port1_rdata <= mem[i_port1_cmd.addr];
      end
    end
  end

endmodule

/* hdl/iob_execute.sv */
`timescale 1ns/1ps
`include "io_buffer_consts.svh"

module iob_execute (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  iob_pkg::bank_cmd_t i_port0_cmd   [`IOB_BANKS],
  input  iob_pkg::bank_cmd_t i_port1_cmd   [`IOB_BANKS],
  input  iob_pkg::rd_tag_t   i_tag,
  output iob_pkg::data_t     o_port0_rdata [`IOB_BANKS],
  output iob_pkg::data_t     o_port1_rdata [`IOB_BANKS],
  output iob_pkg::rd_tag_t   o_tag
);

  // bank array
  for (genvar b = 0; b < `IOB_BANKS; b++) begin : g_bank
    iob_bank bank_i (
      .i_clk         (i_clk),
      .i_port0_cmd   (i_port0_cmd[b]),
      .i_port1_cmd   (i_port1_cmd[b]),
      .o_port0_rdata (o_port0_rdata[b]),
      .o_port1_rdata (o_port1_rdata[b])
    );
  end

  // tag lines up with the bank read data
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_tag <= '0;
    end else begin
      o_tag <= i_tag;
    end
  end

endmodule

/* hdl/iob_result.sv */
`timescale 1ns/1ps
`include "io_buffer_consts.svh"

module iob_result #(
  parameter bit OUT_REG = 1'b0
) (
  input  logic             i_clk,
  input  logic             i_rst_n,
  input  iob_pkg::data_t   i_port0_rdata [`IOB_BANKS],
  input  iob_pkg::data_t   i_port1_rdata [`IOB_BANKS],
  input  iob_pkg::rd_tag_t i_tag,
  output iob_pkg::data_t   o_mdata,
  output logic             o_mdata_vld,
  output iob_pkg::data_t   o_ext_rdata
);

  iob_pkg::data_t int_word;
  iob_pkg::data_t ext_word;

  // ----------------------------------------
  // word select
  // ----------------------------------------

  // zero unless a real bank read came back
  always_comb begin
    if (i_tag.int_vld && !i_tag.pad && !i_tag.blocked) begin
      int_word = i_port0_rdata[i_tag.int_bank];
    end else begin
      int_word = '0;
    end
  end

  assign ext_word = i_port1_rdata[i_tag.ext_bank];

  // ----------------------------------------
  // output stage
  // ----------------------------------------
  if (OUT_REG) begin : g_out_reg
    // ext_rdata loads only on a bus read, so it also holds
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        o_mdata     <= '0;
        o_mdata_vld <= 1'b0;
        o_ext_rdata <= '0;
      end else begin
        o_mdata     <= int_word;
        o_mdata_vld <= i_tag.int_vld;
        if (i_tag.ext_vld) begin
          o_ext_rdata <= ext_word;
        end
      end
    end
  end else begin : g_out_comb
    iob_pkg::data_t ext_hold_q;

    // last bus read word
    always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
        ext_hold_q <= '0;
      end else if (i_tag.ext_vld) begin
        ext_hold_q <= ext_word;
      end
    end

    assign o_mdata     = int_word;
    assign o_mdata_vld = i_tag.int_vld;
    assign o_ext_rdata = i_tag.ext_vld ? ext_word : ext_hold_q;
  end

endmodule

/* hdl/io_buffer.sv */
`timescale 1ns/1ps
`include "io_buffer_consts.svh"

module io_buffer #(
  parameter bit OUT_REG = 1'b0
) (
  input  logic                 i_clk,
  input  logic                 i_rst_n,
  input  iob_pkg::ext_req_t    i_ext_req,
  input  iob_pkg::int_rd_req_t i_int_rd,
  input  iob_pkg::int_wr_req_t i_int_wr,
  output iob_pkg::data_t       o_ext_rdata,
  output iob_pkg::data_t       o_mdata,
  output logic                 o_mdata_vld
);

  iob_pkg::bank_cmd_t port0_cmd   [`IOB_BANKS];
  iob_pkg::bank_cmd_t port1_cmd   [`IOB_BANKS];
  iob_pkg::data_t     port0_rdata [`IOB_BANKS];
  iob_pkg::data_t     port1_rdata [`IOB_BANKS];
  iob_pkg::rd_tag_t   dec_tag;
  iob_pkg::rd_tag_t   exe_tag;

  // bank select and arbitration
  iob_decode decode_i (
    .i_ext_req   (i_ext_req),
    .i_int_rd    (i_int_rd),
    .i_int_wr    (i_int_wr),
    .o_port0_cmd (port0_cmd),
    .o_port1_cmd (port1_cmd),
    .o_tag       (dec_tag)
  );

  iob_execute execute_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_port0_cmd   (port0_cmd),
    .i_port1_cmd   (port1_cmd),
    .i_tag         (dec_tag),
    .o_port0_rdata (port0_rdata),
    .o_port1_rdata (port1_rdata),
    .o_tag         (exe_tag)
  );

  // read data out, optionally registered
  iob_result #(
    .OUT_REG (OUT_REG)
  ) result_i (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_port0_rdata (port0_rdata),
    .i_port1_rdata (port1_rdata),
    .i_tag         (exe_tag),
    .o_mdata       (o_mdata),
    .o_mdata_vld   (o_mdata_vld),
    .o_ext_rdata   (o_ext_rdata)
  );

endmodule

/* dv/io_buffer_sva.sv */
`timescale 1ns/1ps

module io_buffer_sva #(
  parameter bit OUT_REG = 1'b0
) (
  input logic                 i_clk,
  input logic                 i_rst_n,
  input iob_pkg::int_rd_req_t i_int_rd,
  input iob_pkg::data_t       o_mdata,
  input logic                 o_mdata_vld
);

  // edges from request capture to sampled output
  localparam int DLY = OUT_REG ? 2 : 1;

  logic req;
  int   fail_count = 0;

  assign req = i_int_rd.en | i_int_rd.pad;

  vld_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !$isunknown(o_mdata_vld))
    else begin
      $error("o_mdata_vld is unknown");
      fail_count++;
    end

  // valid exactly at the read latency, never elsewhere
  vld_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    req |-> ##DLY o_mdata_vld)
    else begin
      $error("o_mdata_vld missing after a read or pad");
      fail_count++;
    end

  no_vld_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !req |-> ##DLY !o_mdata_vld)
    else begin
      $error("o_mdata_vld high without a read or pad");
      fail_count++;
    end

  pad_is_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_int_rd.pad |-> ##DLY (o_mdata == '0))
    else begin
      $error("o_mdata not zero after a pad");
      fail_count++;
    end

endmodule

bind io_buffer io_buffer_sva #(
  .OUT_REG (OUT_REG)
) sva_i (
  .i_clk       (i_clk),
  .i_rst_n     (i_rst_n),
  .i_int_rd    (i_int_rd),
  .o_mdata     (o_mdata),
  .o_mdata_vld (o_mdata_vld)
);

/* dv/io_buffer_tb.sv */
`timescale 1ns/1ps
`include "io_buffer_consts.svh"

module io_buffer_tb;

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 5;
  // nba drive edge to registered output
  localparam int PIPE_DEPTH = 2;

  typedef struct {
    iob_pkg::ext_req_t    ext;
    iob_pkg::int_rd_req_t rd;
    iob_pkg::int_wr_req_t wr;
    bit                   chk;
  } step_t;

  typedef struct {
    logic           vld;
    iob_pkg::data_t mdata;
    iob_pkg::data_t ext_rdata;
    bit             chk;
  } expect_t;

  logic                 i_clk;
  logic                 i_rst_n;
  iob_pkg::ext_req_t    i_ext_req;
  iob_pkg::int_rd_req_t i_int_rd;
  iob_pkg::int_wr_req_t i_int_wr;
  iob_pkg::data_t       o_ext_rdata;
  iob_pkg::data_t       o_mdata;
  logic                 o_mdata_vld;

  step_t          steps [$];
  expect_t        exp_q [$];
  iob_pkg::data_t mem_model [iob_pkg::addr_t];
  iob_pkg::data_t ext_hold;
  bit             steps_ready = 1'b0;
  int             n_checks;
  int             n_errors;

  io_buffer #(
    .OUT_REG (1'b1)
  ) io_buffer_i (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_ext_req   (i_ext_req),
    .i_int_rd    (i_int_rd),
    .i_int_wr    (i_int_wr),
    .o_ext_rdata (o_ext_rdata),
    .o_mdata     (o_mdata),
    .o_mdata_vld (o_mdata_vld)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ----------------------------------------
  // request builders
  // ----------------------------------------
  function automatic iob_pkg::data_t rand_word();
    iob_pkg::data_t w;
    for (int i = 0; i < `IOB_DATA_W / 32; i++) begin
      w[32*i +: 32] = $urandom;
    end
    return w;
  endfunction

  function automatic iob_pkg::ext_req_t bus_write(iob_pkg::addr_t a, iob_pkg::be_t be,
                                                  iob_pkg::data_t d);
    return '{en: 1'b1, we: 1'b1, be: be, addr: a, wdata: d};
  endfunction

  function automatic iob_pkg::ext_req_t bus_read(iob_pkg::addr_t a);
    return '{en: 1'b1, we: 1'b0, be: '0, addr: a, wdata: '0};
  endfunction

  function automatic iob_pkg::int_rd_req_t rd_req(iob_pkg::addr_t a);
    return '{en: 1'b1, pad: 1'b0, addr: a};
  endfunction

  function automatic iob_pkg::int_rd_req_t pad_req(iob_pkg::addr_t a, logic rd_en);
    return '{en: rd_en, pad: 1'b1, addr: a};
  endfunction

  function automatic iob_pkg::int_wr_req_t wr_req(iob_pkg::addr_t a, iob_pkg::data_t d);
    return '{en: 1'b1, addr: a, wdata: d};
  endfunction

  task automatic add_step(iob_pkg::ext_req_t ext, iob_pkg::int_rd_req_t rd,
                          iob_pkg::int_wr_req_t wr, bit chk = 1'b1);
    steps.push_back('{ext, rd, wr, chk});
  endtask

  task automatic build_table();
    iob_pkg::addr_t spread [4];
    spread = '{12'h005, 12'h40a, 12'h8ff, 12'hc33};
    add_step('0, '0, '0);
    // one word per bank, read back in order
    foreach (spread[i]) begin
      add_step('0, '0, wr_req(spread[i], rand_word()));
    end
    foreach (spread[i]) begin
      add_step('0, rd_req(spread[i]), '0);
    end
    add_step('0, '0, '0);
    // byte lanes merged over an internal word
    add_step('0, '0, wr_req(12'h123, rand_word()));
    add_step(bus_write(12'h123, 32'h0000_ff0f, rand_word()), '0, '0);
    add_step(bus_write(12'h123, 32'hf000_0001, rand_word()), '0, '0);
    add_step(bus_read(12'h123), '0, '0);
    add_step('0, rd_req(12'h123), '0);
    add_step('0, '0, '0);
    // pad with and without a read beside it
    add_step('0, pad_req(12'h005, 1'b1), '0);
    add_step('0, pad_req(12'h8ff, 1'b0), '0);
    add_step('0, rd_req(12'h005), '0);
    // bank 1, bus write takes port 0
    add_step(bus_write(12'h40b, '1, rand_word()), rd_req(12'h40a), '0);
    add_step('0, rd_req(12'h40b), '0);
    add_step(bus_write(12'hc34, '1, rand_word()), rd_req(12'h8ff), '0);
    // bank 2, bus read takes port 1
    add_step('0, '0, wr_req(12'h800, rand_word()));
    add_step(bus_read(12'h8ff), '0, wr_req(12'h800, rand_word()));
    add_step('0, rd_req(12'h800), '0);
    add_step(bus_read(12'hc34), '0, wr_req(12'h3f0, rand_word()));
    // same word read and written, read data undefined
    add_step('0, rd_req(12'h3f0), wr_req(12'h3f0, rand_word()), 1'b0);
    // back to back over all banks
    add_step('0, rd_req(12'hc33), '0);
    add_step('0, rd_req(12'h8ff), '0);
    add_step('0, rd_req(12'h40b), '0);
    add_step(bus_read(12'h40b), rd_req(12'h3f0), '0);
    add_step('0, '0, '0);
    add_step('0, '0, '0);
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  function automatic logic [1:0] bank_of(iob_pkg::addr_t a);
    return a[11:10];
  endfunction

  function automatic iob_pkg::data_t model_read(iob_pkg::addr_t a);
    if (mem_model.exists(a)) begin
      return mem_model[a];
    end
    return 'x;
  endfunction

  task automatic predict(step_t s);
    expect_t        e;
    iob_pkg::data_t merged;
    logic           ext_wr;
    logic           ext_rd;
    ext_wr = s.ext.en & s.ext.we;
    ext_rd = s.ext.en & ~s.ext.we;
    e.vld = s.rd.en | s.rd.pad;
    e.mdata = '0;
    e.chk = s.chk;
    // a blocked read still returns zero with valid
    if (s.rd.en && !s.rd.pad && !(ext_wr && bank_of(s.ext.addr) == bank_of(s.rd.addr))) begin
      e.mdata = model_read(s.rd.addr);
    end
    if (ext_rd) begin
      ext_hold = model_read(s.ext.addr);
    end
    e.ext_rdata = ext_hold;
    // writes land after this cycle's reads
    if (ext_wr) begin
      merged = model_read(s.ext.addr);
      for (int i = 0; i < `IOB_BE_W; i++) begin
        if (s.ext.be[i]) begin
          merged[8*i +: 8] = s.ext.wdata[8*i +: 8];
        end
      end
      mem_model[s.ext.addr] = merged;
    end
    if (s.wr.en && !(ext_rd && bank_of(s.ext.addr) == bank_of(s.wr.addr))) begin
      mem_model[s.wr.addr] = s.wr.wdata;
    end
    exp_q.push_back(e);
  endtask

  task automatic check_value(string what, logic [`IOB_DATA_W-1:0] got,
                             logic [`IOB_DATA_W-1:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    e = exp_q.pop_front();
    check_value("o_mdata_vld", o_mdata_vld, e.vld);
    if (e.chk) begin
      check_value("o_mdata", o_mdata, e.mdata);
      check_value("o_ext_rdata", o_ext_rdata, e.ext_rdata);
    end
  endtask

  initial begin : watchdog
    wait (steps_ready);
    #((steps.size() + 20) * CLK_PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", steps.size() + 20);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    step_t idle_step;
    step_t s;
    int    n_sva;
    i_rst_n = 1'b0;
    i_ext_req = '0;
    i_int_rd = '0;
    i_int_wr = '0;
    n_checks = 0;
    n_errors = 0;
    ext_hold = '0;
    idle_step = '{'0, '0, '0, 1'b1};
    void'($urandom(23248));
    build_table();
    steps_ready = 1'b1;
    // reset state shows while the pipe fills
    repeat (PIPE_DEPTH) begin
      exp_q.push_back('{1'b0, '0, '0, 1'b1});
    end
    repeat (RST_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    for (int j = 0; j < steps.size() + PIPE_DEPTH; j++) begin
      if (j < steps.size()) begin
        s = steps[j];
      end else begin
        s = idle_step;
      end
      @(posedge i_clk);
      i_ext_req <= s.ext;
      i_int_rd  <= s.rd;
      i_int_wr  <= s.wr;
      predict(s);
      @(negedge i_clk);
      check_outputs();
    end
    n_sva = io_buffer_i.sva_i.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", n_checks, n_errors, n_sva);
    if (n_errors == 0 && n_sva == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+hdl
hdl/iob_pkg.sv
hdl/iob_decode.sv
hdl/iob_bank.sv
hdl/iob_execute.sv
hdl/iob_result.sv
hdl/io_buffer.sv
dv/io_buffer_sva.sv
dv/io_buffer_tb.sv

/* Bender.yml */
package:
  name: io_buffer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/iob_pkg.sv
      - hdl/iob_decode.sv
      - hdl/iob_bank.sv
      - hdl/iob_execute.sv
      - hdl/iob_result.sv
      - hdl/io_buffer.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/io_buffer_sva.sv
      - dv/io_buffer_tb.sv
